// ==== src/video_pkg.sv ====
/*
 * shared definitions for the scanline renderer
 *   line, pixel and ROM widths
 *   object and background geometry
 *   background ROM region
 *   graphics word union, planar and packed-nibble views
 */

package video_pkg;

    // line geometry
    localparam int line_w  = 128;   // pixels per line
    localparam int x_w     = 7;     // pixel position width

    // graphics ROM
    localparam int rom_aw  = 15;    // word address
    localparam int gfx_dw  = 32;    // word width

    // objects are 16x16
    localparam int obj_h   = 16;
    localparam int obj_w   = 16;

    // background, one word per 8-pixel column
    localparam int bg_cols = 16;

    // mixed pixel index
    // object:     1, color[2:0], value[1:0]
    // background: 0, 0, nibble[3:0]
    localparam int pix_w   = 6;

    // top address bits of every background fetch
    localparam logic [1:0] bg_region = 2'b10;

    // one ROM word, read two ways
    // objects see two bitplanes, pixel i = {plane1[i], plane0[i]}
    // background sees eight nibbles, nibble 0 leftmost
    typedef union packed {
        logic [1:0][gfx_dw/2-1:0] planar;      // [1] plane1, [0] plane0
        logic [gfx_dw/4-1:0][3:0] packed_pix;  // 4bpp pixels
    } gfx_word_u;

endpackage

// ==== src/gfx_rom_arbiter.sv ====
/*
 * graphics ROM arbiter
 *   round-robin grant between background and object engines
 *   registered request towards the ROM
 *   single outstanding request, response steered to its owner
 */

module gfx_rom_arbiter (
    input  logic                          clk,
    input  logic                          reset,
    // background engine client
    input  logic                          bg_req_valid,
    output logic                          bg_req_ready,
    input  logic [video_pkg::rom_aw-1:0]  bg_req_addr,
    output logic                          bg_rsp_valid,
    output video_pkg::gfx_word_u          bg_rsp_data,
    // object engine client
    input  logic                          obj_req_valid,
    output logic                          obj_req_ready,
    input  logic [video_pkg::rom_aw-1:0]  obj_req_addr,
    output logic                          obj_rsp_valid,
    output video_pkg::gfx_word_u          obj_rsp_data,
    // graphics ROM
    output logic                          rom_req_valid,
    input  logic                          rom_req_ready,
    output logic [video_pkg::rom_aw-1:0]  rom_addr,
    input  logic                          rom_rsp_valid,
    input  video_pkg::gfx_word_u          rom_rsp_data
);

    logic pending;    // granted, response not back yet
    logic owner;      // 1 when the object engine owns it
    logic obj_first;  // round-robin pointer
    logic gnt_bg;
    logic gnt_obj;

    // no new grant until the response is back
    assign gnt_bg  = !pending && bg_req_valid  && (!obj_req_valid || !obj_first);
    assign gnt_obj = !pending && obj_req_valid && (!bg_req_valid  ||  obj_first);

    assign bg_req_ready  = gnt_bg;
    assign obj_req_ready = gnt_obj;

    // data goes to both, valid only to the owner
    assign bg_rsp_valid  = rom_rsp_valid && pending && !owner;
    assign obj_rsp_valid = rom_rsp_valid && pending &&  owner;
    assign bg_rsp_data   = rom_rsp_data;
    assign obj_rsp_data  = rom_rsp_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending       <= 1'b0;
            owner         <= 1'b0;
            obj_first     <= 1'b0;
            rom_req_valid <= 1'b0;
        end else if (gnt_bg || gnt_obj) begin
            pending       <= 1'b1;
            owner         <= gnt_obj;
            obj_first     <= gnt_bg;  // other client first next time
            rom_req_valid <= 1'b1;    // goes out one cycle after grant
        end else begin
            if (rom_req_valid && rom_req_ready)
                rom_req_valid <= 1'b0;
            if (rom_rsp_valid)
                pending <= 1'b0;
        end
    end

    // address held while the ROM stalls
    always_ff @(posedge clk) begin
        if (gnt_bg)
            rom_addr <= bg_req_addr;
        else if (gnt_obj)
            rom_addr <= obj_req_addr;
    end

endmodule

// ==== src/bg_engine.sv ====
/*
 * background engine
 *   one ROM word per 8-pixel column, 16 columns per line
 *   words go straight into the mixer's background buffer
 *   done pulse after the last column
 */

module bg_engine (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          line_start,
    input  logic [7:0]                    line_num,
    // ROM client
    output logic                          req_valid,
    input  logic                          req_ready,
    output logic [video_pkg::rom_aw-1:0]  req_addr,
    input  logic                          rsp_valid,
    input  video_pkg::gfx_word_u          rsp_data,
    // background buffer write
    output logic                          bg_we,
    output logic [3:0]                    bg_waddr,
    output video_pkg::gfx_word_u          bg_wdata,
    output logic                          bg_done
);

    logic [7:0] line_q;  // line being rendered
    logic [3:0] col;     // current column

    // region, spare zero bit, line, column
    assign req_addr = {video_pkg::bg_region, 1'b0, line_q, col};

    // response is written as it arrives
    assign bg_we    = rsp_valid;
    assign bg_waddr = col;
    assign bg_wdata = rsp_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            bg_done   <= 1'b0;
            col       <= 4'd0;
        end else begin
            bg_done <= 1'b0;  // single-cycle pulse
            if (line_start) begin
                col       <= 4'd0;
                req_valid <= 1'b1;
            end else if (req_valid && req_ready) begin
                req_valid <= 1'b0;  // wait for the word
            end
            if (rsp_valid) begin
                if (col == 4'(video_pkg::bg_cols - 1)) begin
                    bg_done <= 1'b1;  // sixteenth word written
                end else begin
                    col       <= col + 4'd1;
                    req_valid <= 1'b1;  // next column
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start)
            line_q <= line_num;
    end

endmodule

// ==== src/obj_engine.sv ====
/*
 * object engine
 *   descriptor intake and line-range test
 *   planar word fetch for objects on the line
 *   16-pixel shifter with horizontal flip, writes into the object buffer
 *   done pulse after the last descriptor
 */

module obj_engine (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          line_start,
    input  logic [7:0]                    line_num,
    // descriptor stream
    input  logic                          obj_valid,
    output logic                          obj_ready,
    input  logic [7:0]                    obj_x,
    input  logic [7:0]                    obj_y,
    input  logic [9:0]                    obj_code,
    input  logic [2:0]                    obj_color,
    input  logic                          obj_hflip,
    input  logic                          obj_last,
    // ROM client
    output logic                          req_valid,
    input  logic                          req_ready,
    output logic [video_pkg::rom_aw-1:0]  req_addr,
    input  logic                          rsp_valid,
    input  video_pkg::gfx_word_u          rsp_data,
    // object buffer write
    output logic                          obj_we,
    output logic [video_pkg::x_w-1:0]     obj_waddr,
    output logic [4:0]                    obj_wpix,
    output logic                          obj_done
);

    logic [7:0]  line_q;
    logic [7:0]  x_q;        // left edge of current object
    logic [2:0]  color_q;
    logic        hflip_q;
    logic        last_q;     // end of list after this one
    logic [15:0] plane1;     // shifters
    logic [15:0] plane0;
    logic        shifting;
    logic [3:0]  cnt;        // pixel being written
    logic [7:0]  row;
    logic        on_line;
    logic        take;
    logic [8:0]  x_pix;      // extra bit catches wrap past 255
    logic [1:0]  pix;

    assign take    = obj_valid && obj_ready;
    assign row     = line_q - obj_y;  // wraps when above the object
    assign on_line = row < 8'(video_pkg::obj_h);

    // flipped reads the top bit, normal the bottom one
    assign pix    = hflip_q ? {plane1[15], plane0[15]} : {plane1[0], plane0[0]};
    assign x_pix  = {1'b0, x_q} + {5'b0, cnt};

    // value 0 is transparent, x past the line is clipped
    assign obj_we    = shifting && (pix != 2'b00) && (x_pix < 9'(video_pkg::line_w));
    assign obj_waddr = x_pix[video_pkg::x_w-1:0];
    assign obj_wpix  = {color_q, pix};

    always_ff @(posedge clk) begin
        if (reset) begin
            obj_ready <= 1'b0;
            req_valid <= 1'b0;
            shifting  <= 1'b0;
            cnt       <= 4'd0;
            obj_done  <= 1'b0;
        end else begin
            obj_done <= 1'b0;
            if (line_start) begin
                obj_ready <= 1'b1;
            end else if (take) begin
                if (on_line) begin
                    obj_ready <= 1'b0;  // hold the list while busy
                    req_valid <= 1'b1;
                end else if (obj_last) begin
                    obj_ready <= 1'b0;  // off-line end marker
                    obj_done  <= 1'b1;
                end
            end
            if (req_valid && req_ready)
                req_valid <= 1'b0;
            if (rsp_valid) begin
                shifting <= 1'b1;
                cnt      <= 4'd0;
            end else if (shifting) begin
                cnt <= cnt + 4'd1;
                if (cnt == 4'(video_pkg::obj_w - 1)) begin
                    shifting <= 1'b0;
                    if (last_q)
                        obj_done <= 1'b1;
                    else
                        obj_ready <= 1'b1;  // next descriptor
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_start)
            line_q <= line_num;
        if (take) begin
            x_q      <= obj_x;
            color_q  <= obj_color;
            hflip_q  <= obj_hflip;
            last_q   <= obj_last;
            req_addr <= {1'b0, obj_code, row[3:0]};
        end
        if (rsp_valid) begin
            {plane1, plane0} <= rsp_data.planar;
        end else if (shifting) begin
            // left when flipped, right otherwise
            plane1 <= hflip_q ? {plane1[14:0], 1'b0} : {1'b0, plane1[15:1]};
            plane0 <= hflip_q ? {plane0[14:0], 1'b0} : {1'b0, plane0[15:1]};
        end
    end

endmodule

// ==== src/line_mixer.sv ====
/*
 * line mixer
 *   background word buffer and object pixel buffer with occupied marks
 *   object-over-background priority
 *   valid/ready scan-out of one line, busy flag
 */

module line_mixer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          line_start,
    output logic                          busy,
    // background side
    input  logic                          bg_we,
    input  logic [3:0]                    bg_waddr,
    input  video_pkg::gfx_word_u          bg_wdata,
    input  logic                          bg_done,
    // object side
    input  logic                          obj_we,
    input  logic [video_pkg::x_w-1:0]     obj_waddr,
    input  logic [4:0]                    obj_wpix,
    input  logic                          obj_done,
    // pixel stream
    output logic                          pix_valid,
    input  logic                          pix_ready,
    output logic [video_pkg::pix_w-1:0]   pix_color,
    output logic                          pix_last
);

    video_pkg::gfx_word_u         bg_buf  [video_pkg::bg_cols];
    logic [4:0]                   obj_buf [video_pkg::line_w];  // color, value
    logic [video_pkg::line_w-1:0] occ;       // object pixel present
    logic                         bg_seen;
    logic                         obj_seen;
    logic [video_pkg::x_w-1:0]    x;         // scan position
    logic                         accept;
    logic                         both;
    logic [3:0]                   nib;

    assign accept = pix_valid && pix_ready;
    assign both   = (bg_seen || bg_done) && (obj_seen || obj_done);

    // column from x[6:3], pixel in the word from x[2:0]
    assign nib       = bg_buf[x[6:3]].packed_pix[x[2:0]];
    assign pix_color = occ[x] ? {1'b1, obj_buf[x]} : {2'b00, nib};
    assign pix_last  = &x;  // x 127

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            bg_seen   <= 1'b0;
            obj_seen  <= 1'b0;
            pix_valid <= 1'b0;
            x         <= '0;
            occ       <= '0;
        end else begin
            if (line_start) begin
                busy     <= 1'b1;
                bg_seen  <= 1'b0;
                obj_seen <= 1'b0;
            end else if (busy && !pix_valid && both) begin
                pix_valid <= 1'b1;  // both engines finished
                x         <= '0;
                bg_seen   <= 1'b0;
                obj_seen  <= 1'b0;
            end else begin
                if (bg_done)
                    bg_seen <= 1'b1;
                if (obj_done)
                    obj_seen <= 1'b1;
            end
            if (obj_we)
                occ[obj_waddr] <= 1'b1;
            if (accept) begin
                occ[x] <= 1'b0;  // clean for the next line
                x      <= x + 1'b1;
                if (pix_last) begin
                    pix_valid <= 1'b0;
                    busy      <= 1'b0;
                end
            end
        end
    end

    // later object writes overwrite earlier ones
    always_ff @(posedge clk) begin
        if (bg_we)
            bg_buf[bg_waddr] <= bg_wdata;
        if (obj_we)
            obj_buf[obj_waddr] <= obj_wpix;
    end

endmodule

// ==== src/video_core.sv ====
/*
 * scanline renderer top level
 *   ROM arbiter, background and object engines, line mixer
 */

module video_core (
    input  logic                          clk,
    input  logic                          reset,
    // line command
    input  logic                          line_start,
    input  logic [7:0]                    line_num,
    output logic                          busy,
    // descriptors
    input  logic                          obj_valid,
    output logic                          obj_ready,
    input  logic [7:0]                    obj_x,
    input  logic [7:0]                    obj_y,
    input  logic [9:0]                    obj_code,
    input  logic [2:0]                    obj_color,
    input  logic                          obj_hflip,
    input  logic                          obj_last,
    // graphics ROM
    output logic                          rom_req_valid,
    input  logic                          rom_req_ready,
    output logic [video_pkg::rom_aw-1:0]  rom_addr,
    input  logic                          rom_rsp_valid,
    input  video_pkg::gfx_word_u          rom_rsp_data,
    // pixels
    output logic                          pix_valid,
    input  logic                          pix_ready,
    output logic [video_pkg::pix_w-1:0]   pix_color,
    output logic                          pix_last
);

    // engine to arbiter
    logic                         bg_req_valid, bg_req_ready, bg_rsp_valid;
    logic                         obj_req_valid, obj_req_ready, obj_rsp_valid;
    logic [video_pkg::rom_aw-1:0] bg_req_addr, obj_req_addr;
    video_pkg::gfx_word_u         bg_rsp_data, obj_rsp_data;
    // engine to mixer
    logic                         bg_we, bg_done, obj_we, obj_done;
    logic [3:0]                   bg_waddr;
    video_pkg::gfx_word_u         bg_wdata;
    logic [video_pkg::x_w-1:0]    obj_waddr;
    logic [4:0]                   obj_wpix;

    gfx_rom_arbiter i_arbiter (.*);

    bg_engine i_bg (
        .clk, .reset, .line_start, .line_num,
        .req_valid(bg_req_valid), .req_ready(bg_req_ready), .req_addr(bg_req_addr),
        .rsp_valid(bg_rsp_valid), .rsp_data(bg_rsp_data),
        .bg_we, .bg_waddr, .bg_wdata, .bg_done
    );

    obj_engine i_obj (
        .clk, .reset, .line_start, .line_num,
        .obj_valid, .obj_ready, .obj_x, .obj_y, .obj_code, .obj_color, .obj_hflip, .obj_last,
        .req_valid(obj_req_valid), .req_ready(obj_req_ready), .req_addr(obj_req_addr),
        .rsp_valid(obj_rsp_valid), .rsp_data(obj_rsp_data),
        .obj_we, .obj_waddr, .obj_wpix, .obj_done
    );

    line_mixer i_mixer (.*);

endmodule

// ==== bench/video_assert.sv ====
/*
 * protocol assertions bound into video_core
 *   ROM request held while stalled
 *   pixel stream held under back-pressure
 *   single outstanding ROM request
 */

module video_assert (
    input logic                          clk,
    input logic                          reset,
    input logic                          rom_req_valid,
    input logic                          rom_req_ready,
    input logic [video_pkg::rom_aw-1:0]  rom_addr,
    input logic                          rom_rsp_valid,
    input logic                          pix_valid,
    input logic                          pix_ready,
    input logic [video_pkg::pix_w-1:0]   pix_color,
    input logic                          pix_last
);

    logic outstanding;  // request accepted and response not yet back

    always_ff @(posedge clk) begin
        if (reset)
            outstanding <= 1'b0;
        else if (rom_req_valid && rom_req_ready)
            outstanding <= 1'b1;
        else if (rom_rsp_valid)
            outstanding <= 1'b0;
    end

    rom_hold: assert property (@(posedge clk) disable iff (reset)
        rom_req_valid && !rom_req_ready |=> rom_req_valid && $stable(rom_addr))
        else begin
            video_tb.assert_errors++;
            $error("ROM request changed while stalled");
        end

    pix_hold: assert property (@(posedge clk) disable iff (reset)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_color) && $stable(pix_last))
        else begin
            video_tb.assert_errors++;
            $error("pixel changed while not accepted");
        end

    one_req: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !rom_req_valid)
        else begin
            video_tb.assert_errors++;
            $error("second ROM request while one is open");
        end

endmodule

// ==== bench/video_tb.sv ====
/*
 * testbench for the scanline renderer
 *   clock, reset, ROM model with random latency and stalls
 *   Galois LFSR, reference line model, compare tasks
 *   directed tests for background, objects, flip, overlap and back-pressure
 */

module video_tb;

    logic clk, reset, line_start, busy;
    logic [7:0] line_num, obj_x, obj_y;
    logic [9:0] obj_code;
    logic [2:0] obj_color;
    logic obj_valid, obj_ready, obj_hflip, obj_last;
    logic rom_req_valid, rom_req_ready, rom_rsp_valid;
    logic [video_pkg::rom_aw-1:0] rom_addr;
    video_pkg::gfx_word_u rom_rsp_data;
    logic pix_valid, pix_ready, pix_last;
    logic [video_pkg::pix_w-1:0] pix_color;

    logic [31:0] rom_mem [2**video_pkg::rom_aw];
    logic [31:0] lfsr;
    logic [video_pkg::pix_w-1:0] exp_pix [video_pkg::line_w];  // reference line
    logic [7:0] d_x [8], d_y [8];  // descriptor list of the line
    logic [9:0] d_code [8];
    logic [2:0] d_color [8];
    logic d_hflip [8];
    int n_obj;
    logic stall_en = 1'b0, bp_en = 1'b0;  // random ROM stalls, pix_ready gaps
    int mismatch_errors = 0, timeout_errors = 0, assert_errors = 0;

    video_core i_dut (.*);
    bind video_core video_assert i_assert (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;  // x^32+x^22+x^2+x+1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // ROM model and pix_ready driver with handshakes sampled at the falling edge
    initial begin : rom_model
        logic hs;
        logic pend;
        logic [video_pkg::rom_aw-1:0] a;
        logic [31:0] r;
        int wait_cnt;
        rom_req_ready = 1'b1;
        rom_rsp_valid = 1'b0;
        rom_rsp_data  = '0;
        pix_ready     = 1'b1;
        pend          = 1'b0;
        wait_cnt      = 0;
        forever begin
            @(negedge clk);
            hs = rom_req_valid && rom_req_ready && !reset;
            if (hs)
                a = rom_addr;
            @(posedge clk);
            #2;
            rom_rsp_valid = 1'b0;
            if (hs) begin
                pend = 1'b1;
                rand_bits(2, r);
                wait_cnt = r;  // latency 1 to 4
            end
            if (pend && wait_cnt == 0) begin
                rom_rsp_valid = 1'b1;
                rom_rsp_data  = rom_mem[a];
                pend          = 1'b0;
            end else if (pend) begin
                wait_cnt--;
            end
            rand_bits(2, r);
            rom_req_ready = !stall_en || r[0];
            pix_ready     = !bp_en || r[1];
        end
    end

    task automatic check_pix(input int x, input logic [video_pkg::pix_w-1:0] got, exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("MISMATCH %0t pix_color x=%0d got %h expected %h", $time, x, got, exp);
        end
    endtask

    task automatic check_last(input int x, input logic got, exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("MISMATCH %0t pix_last x=%0d got %b expected %b", $time, x, got, exp);
        end
    endtask

    task automatic check_busy(input logic got, exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("MISMATCH %0t busy got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic clear_objs();
        n_obj = 0;
    endtask

    task automatic add_obj(input logic [7:0] x, y, input logic [9:0] code,
                           input logic [2:0] color, input logic hflip);
        d_x[n_obj]     = x;
        d_y[n_obj]     = y;
        d_code[n_obj]  = code;
        d_color[n_obj] = color;
        d_hflip[n_obj] = hflip;
        n_obj++;
    endtask

    // expected line from ROM contents and descriptor list
    task automatic build_expected(input logic [7:0] line);
        logic [31:0] w;
        logic [7:0] row;
        logic [8:0] px;
        logic [1:0] v;
        int b;
        for (int x = 0; x < video_pkg::line_w; x++) begin
            w = rom_mem[{video_pkg::bg_region, 1'b0, line, 4'(x / 8)}];
            exp_pix[x] = {2'b00, w[4 * (x % 8) +: 4]};  // nibble 0 leftmost
        end
        for (int k = 0; k < n_obj; k++) begin
            row = line - d_y[k];
            if (row < 8'd16) begin
                w = rom_mem[{1'b0, d_code[k], row[3:0]}];
                for (int i = 0; i < 16; i++) begin
                    b  = d_hflip[k] ? 15 - i : i;
                    v  = {w[16 + b], w[b]};  // plane1 over plane0
                    px = {1'b0, d_x[k]} + 9'(i);
                    if (v != 2'b00 && px < 9'd128)
                        exp_pix[px[6:0]] = {1'b1, d_color[k], v};  // later one wins
                end
            end
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (busy && t < 100) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (busy) begin
            timeout_errors++;
            $display("timeout at %0t: busy did not fall after the line", $time);
        end
    endtask

    task automatic run_line(input logic [7:0] line);
        int t;
        int x;
        build_expected(line);
        wait_idle();
        line_num   = line;
        line_start = 1'b1;
        @(posedge clk);
        #2;
        line_start = 1'b0;
        check_busy(busy, 1'b1);  // set the cycle after line_start
        for (int k = 0; k < n_obj; k++) begin
            obj_x     = d_x[k];
            obj_y     = d_y[k];
            obj_code  = d_code[k];
            obj_color = d_color[k];
            obj_hflip = d_hflip[k];
            obj_last  = (k == n_obj - 1);  // end of list
            obj_valid = 1'b1;
            t = 0;
            while (!obj_ready && t < 400) begin
                @(posedge clk);
                #2;
                t++;
            end
            if (!obj_ready) begin
                timeout_errors++;
                $display("timeout at %0t: descriptor %0d of line %0d not taken", $time, k, line);
            end
            @(posedge clk);  // transfer edge
            #2;
        end
        obj_valid = 1'b0;
        x = 0;
        t = 0;
        while (x < video_pkg::line_w && t < 2000) begin
            @(negedge clk);
            if (pix_valid && pix_ready) begin
                check_pix(x, pix_color, exp_pix[x]);
                check_last(x, pix_last, x == video_pkg::line_w - 1);
                x++;
                t = 0;
            end else begin
                t++;
            end
        end
        if (x < video_pkg::line_w) begin
            timeout_errors++;
            $display("timeout at %0t: line %0d stopped after %0d pixels", $time, line, x);
        end
        wait_idle();
    endtask

    task automatic bg_only_line();
        clear_objs();
        add_obj(8'd0, 8'd100, 10'd1, 3'd0, 1'b0);  // off-line end marker
        run_line(8'd5);
    endtask

    task automatic one_obj_line(input logic hflip);
        clear_objs();
        add_obj(8'd40, 8'd10, 10'd7, 3'd5, hflip);  // row 10
        run_line(8'd20);
    endtask

    task automatic overlap_clip_line();
        clear_objs();
        add_obj(8'd30, 8'd40, 10'd3, 3'd2, 1'b0);
        add_obj(8'd38, 8'd45, 10'd9, 3'd6, 1'b1);   // covers part of the first
        add_obj(8'd120, 8'd50, 10'd12, 3'd1, 1'b0); // cut at x 127
        add_obj(8'd60, 8'd70, 10'd4, 3'd7, 1'b0);   // row wraps so it misses the line
        run_line(8'd50);
    endtask

    task automatic backpressure_lines();
        @(negedge clk);
        stall_en = 1'b1;
        bp_en    = 1'b1;
        @(posedge clk);
        #2;
        for (int n = 0; n < 4; n++) begin
            clear_objs();
            add_obj(8'(13 * n + 5), 8'(60 + n), 10'(100 + 37 * n), 3'(n + 1), n[0]);
            add_obj(8'(13 * n + 11), 8'(50 + n), 10'(200 + n), 3'(7 - n), !n[0]);
            add_obj(8'(118 + n), 8'd55, 10'(300 + n), 3'(n), 1'b0);
            run_line(8'(64 + n));
        end
        @(negedge clk);
        stall_en = 1'b0;
        bp_en    = 1'b0;
        @(posedge clk);
        #2;
    endtask

    initial begin
        logic [31:0] w;
        reset      = 1'b1;
        line_start = 1'b0;
        line_num   = '0;
        obj_valid  = 1'b0;
        obj_x      = '0;
        obj_y      = '0;
        obj_code   = '0;
        obj_color  = '0;
        obj_hflip  = 1'b0;
        obj_last   = 1'b0;
        lfsr       = 32'hec43;
        for (int a = 0; a < 2**video_pkg::rom_aw; a++) begin
            rand_bits(32, w);
            rom_mem[a] = w;
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        bg_only_line();
        one_obj_line(1'b0);
        one_obj_line(1'b1);  // same object mirrored
        overlap_clip_line();
        backpressure_lines();
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_errors, timeout_errors, assert_errors);
        if (mismatch_errors + timeout_errors + assert_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== project.f ====
src/video_pkg.sv
src/gfx_rom_arbiter.sv
src/bg_engine.sv
src/obj_engine.sv
src/line_mixer.sv
src/video_core.sv
bench/video_assert.sv
bench/video_tb.sv
